//--- filelist.f
+incdir+source
source/rename_pkg.sv
source/recovery_if.sv
source/inst_decoder.sv
source/free_list.sv
source/maptable.sv
source/rename_rob.sv
source/rename_top.sv
tb/rename_tb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = rename_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/rename_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_config.svh"

module rename_tb;

   localparam int CYCLES        = 3000;
   localparam int RECOVER_LIMIT = 40;

   typedef struct {
      logic [`ARF_WIDTH-1:0] rs1;
      logic [`ARF_WIDTH-1:0] rs2;
      logic [`ARF_WIDTH-1:0] rd;
      bit                    wr;
      bit                    br;
   } slot_t;

   typedef struct {
      logic [`ARF_WIDTH-1:0] rd;
      bit                    valid;
      logic [`PRF_WIDTH-1:0] t;
      logic [`PRF_WIDTH-1:0] t_old;
      bit                    br;
      logic [`ROB_WIDTH-1:0] idx;
   } entry_t;

   logic                  clk;
   logic                  reset_n;
   logic                  instr_valid;
   logic [31:0]           instr_0;
   logic [31:0]           instr_1;
   logic                  retire_req;
   logic                  mispredict;
   logic [`ROB_WIDTH-1:0] mispredict_tag;
   logic                  stall;
   logic [`ROB_WIDTH-1:0] tag_0;
   logic [`PRF_WIDTH-1:0] instr0_prf_rs1;
   logic [`PRF_WIDTH-1:0] instr0_prf_rs2;
   logic [`PRF_WIDTH-1:0] instr1_prf_rs1;
   logic [`PRF_WIDTH-1:0] instr1_prf_rs2;
   logic [`PRF_WIDTH-1:0] T_0;
   logic [`PRF_WIDTH-1:0] T_1;
   logic [`PRF_WIDTH-1:0] T_old_0;
   logic [`PRF_WIDTH-1:0] T_old_1;

   // Reference model
   logic [`PRF_WIDTH-1:0] rat  [`ARF_NUM];
   logic [`PRF_WIDTH-1:0] rrat [`ARF_NUM];
   logic [`PRF_WIDTH-1:0] fl   [$];
   entry_t                rob  [$];
   logic [`ROB_WIDTH-1:0] rob_tail;
   int                    pending;   // Retires claimed for the next edge
   int                    n_renamed;
   int                    n_flushes;
   slot_t                 s0;
   slot_t                 s1;

   rename_top dut0 (
      .clk(clk), .reset_n(reset_n), .instr_valid(instr_valid),
      .instr_0(instr_0), .instr_1(instr_1), .retire_req(retire_req),
      .mispredict(mispredict), .mispredict_tag(mispredict_tag),
      .stall(stall), .tag_0(tag_0),
      .instr0_prf_rs1(instr0_prf_rs1), .instr0_prf_rs2(instr0_prf_rs2),
      .instr1_prf_rs1(instr1_prf_rs1), .instr1_prf_rs2(instr1_prf_rs2),
      .T_0(T_0), .T_1(T_1), .T_old_0(T_old_0), .T_old_1(T_old_1)
   );

   always #2 clk = ~clk;

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected) begin
         $display("[ERROR] %0t: %s got %0d, expected %0d", $time, what, actual, expected);
         $display("SIMULATION FAILED");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   function automatic logic [`ARF_WIDTH-1:0] pick_reg();
      if ($urandom_range(0, 1) == 0)
         return `ARF_WIDTH'($urandom_range(0, 7)); // Small set for more hazards
      return `ARF_WIDTH'($urandom_range(0, `ARF_NUM - 1));
   endfunction

   // Slot 1 lookup with the same-cycle slot 0 destination
   function automatic logic [`PRF_WIDTH-1:0] slot1_map(input logic [`ARF_WIDTH-1:0] id);
      if (s0.wr && id == s0.rd)
         return fl[0];
      return rat[id];
   endfunction

   task automatic make_slot(output slot_t s, output logic [31:0] word,
                            input bit near, input logic [`ARF_WIDTH-1:0] near_rd);
      int                    k;
      logic [`ARF_WIDTH-1:0] rs1;
      logic [`ARF_WIDTH-1:0] rs2;
      logic [`ARF_WIDTH-1:0] rd;
      bit                    use1;
      bit                    use2;
      bit                    userd;
      k   = $urandom_range(0, 5);
      rs1 = pick_reg();
      rs2 = pick_reg();
      rd  = pick_reg();
      if (near && $urandom_range(0, 2) == 0) rs1 = near_rd;
      if (near && $urandom_range(0, 2) == 0) rs2 = near_rd;
      if (near && $urandom_range(0, 3) == 0) rd = near_rd;
      word  = $urandom();
      use1  = 1'b1;
      use2  = 1'b0;
      userd = 1'b1;
      s.br  = 1'b0;
      case (k)
         0: begin
            word[6:0] = rename_pkg::op_alu;
            use2      = 1'b1;
         end
         1: word[6:0] = rename_pkg::op_alui;
         2: word[6:0] = rename_pkg::op_load;
         3: begin
            word[6:0] = rename_pkg::op_store;
            use2      = 1'b1;
            userd     = 1'b0;
         end
         4: begin
            word[6:0] = rename_pkg::op_branch;
            use2      = 1'b1;
            userd     = 1'b0;
            s.br      = 1'b1;
         end
         default: begin
            word[6:0] = rename_pkg::op_lui;
            use1      = 1'b0;
         end
      endcase
      word[11:7]  = rd;
      word[19:15] = rs1;
      word[24:20] = rs2;
      s.rs1 = use1 ? rs1 : '0;
      s.rs2 = use2 ? rs2 : '0;
      s.rd  = userd ? rd : '0;
      s.wr  = userd && rd != '0; // x0 is never renamed
   endtask

   // Oldest claimed entries leave the ROB
   task automatic retire_pending();
      entry_t e;
      repeat (pending) begin
         e = rob.pop_front();
         if (e.valid) begin
            rrat[e.rd] = e.t;
            fl.push_back(e.t_old);
         end
      end
   endtask

   //////////////////////////////
   // One normal cycle
   //////////////////////////////

   task automatic normal_cycle(input int cyc);
      logic [31:0]           w0;
      logic [31:0]           w1;
      logic [`PRF_WIDTH-1:0] t0;
      logic [`PRF_WIDTH-1:0] t1;
      logic [`PRF_WIDTH-1:0] old0;
      logic [`PRF_WIDTH-1:0] old1;
      bit                    exp_stall;
      bit                    acc;
      int                    retire_pct;
      int                    ret_next;
      entry_t                e;
      make_slot(s0, w0, 1'b0, '0);
      make_slot(s1, w1, 1'b1, s0.rd);
      retire_pct  = ((cyc / 150) % 2 == 0) ? 60 : 12; // Phases that fill the ROB
      instr_0     = w0;
      instr_1     = w1;
      instr_valid = ($urandom_range(0, 3) != 0);
      retire_req  = ($urandom_range(0, 99) < retire_pct);
      mispredict  = 1'b0;
      #1;
      exp_stall = fl.size() < 2 || (`ROB_DEPTH - rob.size()) < 2;
      acc       = instr_valid && !exp_stall;
      t0        = fl[0];
      t1        = s0.wr ? fl[1] : fl[0];
      old0      = rat[s0.rd];
      old1      = slot1_map(s1.rd);
      check(stall, exp_stall, "stall");
      check(tag_0, rob_tail, "tag_0");
      check(instr0_prf_rs1, rat[s0.rs1], "instr0_prf_rs1");
      check(instr0_prf_rs2, rat[s0.rs2], "instr0_prf_rs2");
      check(instr1_prf_rs1, slot1_map(s1.rs1), "instr1_prf_rs1");
      check(instr1_prf_rs2, slot1_map(s1.rs2), "instr1_prf_rs2");
      check(T_old_0, old0, "T_old_0");
      check(T_old_1, old1, "T_old_1");
      if (acc && s0.wr) check(T_0, t0, "T_0");
      if (acc && s1.wr) check(T_1, t1, "T_1");

      // Model update for the next rising edge
      ret_next = rob.size() - pending;
      if (ret_next > 2) ret_next = 2;
      retire_pending();
      pending = retire_req ? ret_next : 0;
      if (acc) begin
         n_renamed++;
         e = '{rd: s0.rd, valid: s0.wr, t: t0, t_old: old0, br: s0.br, idx: rob_tail};
         rob.push_back(e);
         e = '{rd: s1.rd, valid: s1.wr, t: t1, t_old: old1, br: s1.br, idx: rob_tail + 1'b1};
         rob.push_back(e);
         if (s0.wr) void'(fl.pop_front());
         if (s1.wr) void'(fl.pop_front());
         if (s0.wr) rat[s0.rd] = t0;
         if (s1.wr) rat[s1.rd] = t1; // Slot 1 wins a WAW pair
         rob_tail = rob_tail + 2'd2;
      end
   endtask

   //////////////////////////////
   // Mispredict and recovery
   //////////////////////////////

   task automatic try_mispredict(output bit issued);
      int                    cand [$];
      logic [`PRF_WIDTH-1:0] sq   [$];
      int                    q;
      int                    p;
      int                    even;
      int                    waited;
      issued = 1'b0;
      for (int i = pending; i < rob.size(); i++) begin
         even = !rob[i].idx[0];
         if (rob[i].br && (i - pending + 1 + even) <= `ROB_DEPTH - 2)
            cand.push_back(i);
      end
      if (cand.size() == 0) return;
      issued         = 1'b1;
      n_flushes++;
      q              = cand[$urandom_range(0, cand.size() - 1)];
      even           = !rob[q].idx[0];
      instr_valid    = 1'b0;
      retire_req     = 1'b0;
      mispredict     = 1'b1;
      mispredict_tag = rob[q].idx;
      #1;
      check(stall, fl.size() < 2 || (`ROB_DEPTH - rob.size()) < 2, "stall at mispredict");

      p = q - pending;
      retire_pending();
      pending = 0;
      for (int i = p + 1; i < rob.size(); i++)
         if (rob[i].valid) sq.push_back(rob[i].t);
      while (rob.size() > p + 1 + even)
         void'(rob.pop_back());
      if (even) rob[p + 1].valid = 1'b0; // Slot 1 behind the branch is a bubble
      for (int i = sq.size() - 1; i >= 0; i--)
         fl.push_front(sq[i]);
      rob_tail = rob[p].idx + `ROB_WIDTH'(even ? 2 : 1);
      rat = rrat;
      foreach (rob[i])
         if (rob[i].valid) rat[rob[i].rd] = rob[i].t;

      @(negedge clk);
      mispredict  = 1'b0;
      instr_valid = 1'b1; // Offered under stall and must not be taken
      retire_req  = ($urandom_range(0, 1) == 1); // Ignored while recovering
      check(stall, 1'b1, "stall during recovery");
      waited = 0;
      while (stall) begin
         @(negedge clk);
         retire_req = ($urandom_range(0, 1) == 1);
         waited++;
         if (waited > RECOVER_LIMIT) begin
            $display("Timeout: stall did not fall after a mispredict");
            $display("SIMULATION FAILED");
            $fatal(1, "Recovery timeout");
         end
      end
      instr_valid = 1'b0;
      retire_req  = 1'b0;
   endtask

   initial begin
      bit issued;
      void'($urandom(65978));
      clk            = 1'b0;
      reset_n        = 1'b0;
      instr_valid    = 1'b0;
      instr_0        = '0;
      instr_1        = '0;
      retire_req     = 1'b0;
      mispredict     = 1'b0;
      mispredict_tag = '0;
      n_renamed      = 0;
      n_flushes      = 0;
      pending        = 0;
      rob_tail       = '0;
      for (int i = 0; i < `ARF_NUM; i++) begin
         rat[i]  = `PRF_WIDTH'(i);
         rrat[i] = `PRF_WIDTH'(i);
      end
      for (int i = `ARF_NUM; i < `PRF_NUM; i++)
         fl.push_back(`PRF_WIDTH'(i));
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset_n = 1'b1;

      for (int cyc = 0; cyc < CYCLES; cyc++) begin
         @(negedge clk);
         issued = 1'b0;
         if ($urandom_range(0, 24) == 0)
            try_mispredict(issued);
         if (!issued)
            normal_cycle(cyc);
      end
      $display("Renamed pairs: %0d, mispredicts: %0d", n_renamed, n_flushes);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- source/rename_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_config.svh"

module rename_top (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  instr_valid,
   input  logic [31:0]           instr_0,
   input  logic [31:0]           instr_1,
   input  logic                  retire_req,
   input  logic                  mispredict,
   input  logic [`ROB_WIDTH-1:0] mispredict_tag,
   output logic                  stall,
   output logic [`ROB_WIDTH-1:0] tag_0,
   output logic [`PRF_WIDTH-1:0] instr0_prf_rs1,
   output logic [`PRF_WIDTH-1:0] instr0_prf_rs2,
   output logic [`PRF_WIDTH-1:0] instr1_prf_rs1,
   output logic [`PRF_WIDTH-1:0] instr1_prf_rs2,
   output logic [`PRF_WIDTH-1:0] T_0,
   output logic [`PRF_WIDTH-1:0] T_1,
   output logic [`PRF_WIDTH-1:0] T_old_0,
   output logic [`PRF_WIDTH-1:0] T_old_1
);

   rename_pkg::rename_type dec_0;
   rename_pkg::rename_type dec_1;
   rename_pkg::rename_type rename_0;
   rename_pkg::rename_type rename_1;
   logic [`PRF_WIDTH-1:0]  alloc_prf_0;
   logic [`PRF_WIDTH-1:0]  alloc_prf_1;
   logic [`PRF_WIDTH:0]    free_count;
   logic [`ROB_WIDTH:0]    free_entries;
   logic                   recovering;
   logic                   accept;
   logic                   alloc_0;
   logic                   alloc_1;

   recovery_if rec ();

   // Hold the pair while recovering or short of registers or ROB slots
   assign stall  = recovering || free_count < 2 || free_entries < 2;
   assign accept = instr_valid && !stall;

   assign alloc_0 = accept && dec_0.rd_valid;
   assign alloc_1 = accept && dec_1.rd_valid;

   // Free list heads merged into the decoded slots
   always_comb begin
      rename_0           = dec_0;
      rename_0.fl_prf_id = alloc_prf_0;
      rename_1           = dec_1;
      rename_1.fl_prf_id = alloc_prf_1;
   end

   inst_decoder u_decoder (
      .instr_0  (instr_0),
      .instr_1  (instr_1),
      .rename_0 (dec_0),
      .rename_1 (dec_1)
   );

   free_list u_free_list (
      .clk         (clk),
      .reset_n     (reset_n),
      .alloc_0     (alloc_0),
      .alloc_1     (alloc_1),
      .alloc_prf_0 (alloc_prf_0),
      .alloc_prf_1 (alloc_prf_1),
      .free_count  (free_count),
      .rec         (rec.sink)
   );

   maptable u_maptable (
      .clk            (clk),
      .reset_n        (reset_n),
      .rename_0       (rename_0),
      .rename_1       (rename_1),
      .rename_en      (accept),
      .instr0_prf_rs1 (instr0_prf_rs1),
      .instr0_prf_rs2 (instr0_prf_rs2),
      .instr1_prf_rs1 (instr1_prf_rs1),
      .instr1_prf_rs2 (instr1_prf_rs2),
      .T_0            (T_0),
      .T_1            (T_1),
      .T_old_0        (T_old_0),
      .T_old_1        (T_old_1),
      .rec            (rec.sink)
   );

   rename_rob u_rob (
      .clk            (clk),
      .reset_n        (reset_n),
      .push           (accept),
      .rename_0       (rename_0),
      .rename_1       (rename_1),
      .T_0            (T_0),
      .T_1            (T_1),
      .T_old_0        (T_old_0),
      .T_old_1        (T_old_1),
      .retire_req     (retire_req),
      .mispredict     (mispredict),
      .mispredict_tag (mispredict_tag),
      .tag_0          (tag_0),
      .free_entries   (free_entries),
      .recovering     (recovering),
      .rec            (rec.source)
   );

endmodule

`default_nettype wire

//--- source/rename_rob.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_config.svh"

module rename_rob (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   push,
   input  rename_pkg::rename_type rename_0,
   input  rename_pkg::rename_type rename_1,
   input  logic [`PRF_WIDTH-1:0]  T_0,
   input  logic [`PRF_WIDTH-1:0]  T_1,
   input  logic [`PRF_WIDTH-1:0]  T_old_0,
   input  logic [`PRF_WIDTH-1:0]  T_old_1,
   input  logic                   retire_req,
   input  logic                   mispredict,
   input  logic [`ROB_WIDTH-1:0]  mispredict_tag,
   output logic [`ROB_WIDTH-1:0]  tag_0,
   output logic [`ROB_WIDTH:0]    free_entries,
   output logic                   recovering,
   recovery_if.source             rec
);

   logic [`ARF_WIDTH-1:0]  ent_rd_id    [`ROB_DEPTH];
   logic                   ent_rd_valid [`ROB_DEPTH];
   logic [`PRF_WIDTH-1:0]  ent_t        [`ROB_DEPTH];
   logic [`PRF_WIDTH-1:0]  ent_t_old    [`ROB_DEPTH];

   rename_pkg::rob_state_e state;
   logic [`ROB_WIDTH:0]    head;     // Extra bit tells full from empty
   logic [`ROB_WIDTH:0]    tail;
   logic [`ROB_WIDTH:0]    walk_ptr;
   logic [`ROB_WIDTH:0]    count;
   logic [`ROB_WIDTH:0]    ret_left;
   logic [`ROB_WIDTH:0]    walk_left;
   logic [`ROB_WIDTH:0]    keep;
   logic [`ROB_WIDTH:0]    squash;
   logic [`ROB_WIDTH:0]    squash_q;
   logic [`ROB_WIDTH-1:0]  tail_idx;
   logic [`ROB_WIDTH-1:0]  rd_idx_0;
   logic [`ROB_WIDTH-1:0]  rd_idx_1;
   logic [`ROB_WIDTH-1:0]  br_dist;
   logic [1:0]             ret_num;  // Entries retiring at the next edge
   logic [1:0]             ret_next;
   logic                   retire_ok;
   logic                   flush;
   logic                   retire_0;
   logic                   retire_1;

   assign count        = tail - head;
   assign free_entries = (`ROB_WIDTH+1)'(`ROB_DEPTH) - count;
   assign tail_idx     = tail[`ROB_WIDTH-1:0];
   assign tag_0        = tail_idx;
   assign recovering   = (state != rename_pkg::rob_idle);

   assign flush     = mispredict && state == rename_pkg::rob_idle;
   assign retire_ok = retire_req && state == rename_pkg::rob_idle && !mispredict;
   assign ret_left  = count - (`ROB_WIDTH+1)'(ret_num); // Not yet claimed
   assign ret_next  = (ret_left >= 2) ? 2'd2 : ret_left[1:0];

   // Branch pair is kept whole and its slot 1 turns into a bubble
   assign br_dist = mispredict_tag - head[`ROB_WIDTH-1:0];
   assign keep    = {1'b0, br_dist} + (mispredict_tag[0] ? 5'd1 : 5'd2);

   always_comb begin
      squash = '0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
         if ((`ROB_WIDTH+1)'(i) > {1'b0, br_dist} && (`ROB_WIDTH+1)'(i) < count &&
             ent_rd_valid[head[`ROB_WIDTH-1:0] + `ROB_WIDTH'(i)])
            squash = squash + 1'b1;
      end
      // A pair renamed in the same cycle is younger too
      if (push)
         squash = squash + rename_0.rd_valid + rename_1.rd_valid;
   end

   //////////////////////////////
   // Retire and walk read port
   //////////////////////////////

   assign rd_idx_0  = (state == rename_pkg::rob_walk) ? walk_ptr[`ROB_WIDTH-1:0]
                                                      : head[`ROB_WIDTH-1:0];
   assign rd_idx_1  = rd_idx_0 + 1'b1;
   assign walk_left = tail - walk_ptr;

   assign retire_0 = (ret_num != 2'd0) && ent_rd_valid[rd_idx_0];
   assign retire_1 = (ret_num == 2'd2) && ent_rd_valid[rd_idx_1];

   assign rec.rob_state       = state;
   assign rec.retire_valid_0  = retire_0;
   assign rec.retire_valid_1  = retire_1;
   assign rec.retire_arf_id_0 = ent_rd_id[rd_idx_0];
   assign rec.retire_arf_id_1 = ent_rd_id[rd_idx_1];
   assign rec.retire_prf_id_0 = ent_t[rd_idx_0];
   assign rec.retire_prf_id_1 = ent_t[rd_idx_1];
   assign rec.release_valid_0 = retire_0;
   assign rec.release_valid_1 = retire_1;
   assign rec.release_prf_0   = ent_t_old[rd_idx_0];
   assign rec.release_prf_1   = ent_t_old[rd_idx_1];

   assign rec.walk_valid_0  = (state == rename_pkg::rob_walk) && walk_left != '0 &&
                              ent_rd_valid[rd_idx_0];
   assign rec.walk_valid_1  = (state == rename_pkg::rob_walk) && walk_left > 1 &&
                              ent_rd_valid[rd_idx_1];
   assign rec.walk_rd_id_0  = ent_rd_id[rd_idx_0];
   assign rec.walk_rd_id_1  = ent_rd_id[rd_idx_1];
   assign rec.walk_rd_prf_0 = ent_t[rd_idx_0];
   assign rec.walk_rd_prf_1 = ent_t[rd_idx_1];
   assign rec.squash_count  = squash_q;

   //////////////////////////////
   // Pointers and recovery FSM
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state    <= rename_pkg::rob_idle;
         head     <= '0;
         tail     <= '0;
         walk_ptr <= '0;
         ret_num  <= 2'd0;
         squash_q <= '0;
      end else begin
         head    <= head + (`ROB_WIDTH+1)'(ret_num);
         ret_num <= retire_ok ? ret_next : 2'd0;
         if (flush)
            tail <= head + keep; // Just past the branch pair
         else if (push)
            tail <= tail + 2'd2;
         case (state)
            rename_pkg::rob_idle: begin
               if (flush) begin
                  state    <= rename_pkg::rob_rollback;
                  squash_q <= squash;
               end
            end
            rename_pkg::rob_rollback: begin
               state    <= rename_pkg::rob_walk;
               walk_ptr <= head;
            end
            rename_pkg::rob_walk: begin
               if (walk_left <= 2)
                  state <= rename_pkg::rob_idle; // Branch reached
               else
                  walk_ptr <= walk_ptr + 2'd2;
            end
            default: state <= rename_pkg::rob_idle;
         endcase
      end
   end

   // Entry payload with slot 0 at the even index
   always_ff @(posedge clk) begin
      if (push && !flush) begin
         ent_rd_id[tail_idx]           <= rename_0.rd_id;
         ent_rd_valid[tail_idx]        <= rename_0.rd_valid;
         ent_t[tail_idx]               <= T_0;
         ent_t_old[tail_idx]           <= T_old_0;
         ent_rd_id[tail_idx + 1'b1]    <= rename_1.rd_id;
         ent_rd_valid[tail_idx + 1'b1] <= rename_1.rd_valid;
         ent_t[tail_idx + 1'b1]        <= T_1;
         ent_t_old[tail_idx + 1'b1]    <= T_old_1;
      end
      if (flush && !mispredict_tag[0])
         ent_rd_valid[mispredict_tag + 1'b1] <= 1'b0;
   end

endmodule

`default_nettype wire

//--- source/maptable.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_config.svh"

module maptable (
   input  logic                   clk,
   input  logic                   reset_n,
   input  rename_pkg::rename_type rename_0,
   input  rename_pkg::rename_type rename_1,
   input  logic                   rename_en,
   output logic [`PRF_WIDTH-1:0]  instr0_prf_rs1,
   output logic [`PRF_WIDTH-1:0]  instr0_prf_rs2,
   output logic [`PRF_WIDTH-1:0]  instr1_prf_rs1,
   output logic [`PRF_WIDTH-1:0]  instr1_prf_rs2,
   output logic [`PRF_WIDTH-1:0]  T_0,
   output logic [`PRF_WIDTH-1:0]  T_1,
   output logic [`PRF_WIDTH-1:0]  T_old_0,
   output logic [`PRF_WIDTH-1:0]  T_old_1,
   recovery_if.sink               rec
);

   logic [`PRF_WIDTH-1:0] rat  [`ARF_NUM]; // Speculative
   logic [`PRF_WIDTH-1:0] rrat [`ARF_NUM]; // Retired

   // Slot 1 lookup sees slot 0's new register (RAW and WAW)
   function automatic logic [`PRF_WIDTH-1:0] slot1_read(input logic [`ARF_WIDTH-1:0] id);
      if (rename_0.rd_valid && id == rename_0.rd_id)
         return rename_0.fl_prf_id;
      return rat[id];
   endfunction

   //////////////////////////////
   // RAT read
   //////////////////////////////

   assign instr0_prf_rs1 = rat[rename_0.rs1_id];
   assign instr0_prf_rs2 = rat[rename_0.rs2_id];

   always_comb begin
      instr1_prf_rs1 = slot1_read(rename_1.rs1_id);
      instr1_prf_rs2 = slot1_read(rename_1.rs2_id);
      T_old_1        = slot1_read(rename_1.rd_id);
   end

   assign T_0     = rename_0.fl_prf_id;
   assign T_1     = rename_1.fl_prf_id;
   assign T_old_0 = rat[rename_0.rd_id];

   //////////////////////////////
   // RAT write
   //////////////////////////////

   // Slot 1 is written last, so it wins a same-register pair
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `ARF_NUM; i++)
            rat[i] <= `PRF_WIDTH'(i);
      end else if (rec.rob_state == rename_pkg::rob_rollback) begin
         rat <= rrat;
      end else if (rec.rob_state == rename_pkg::rob_walk) begin
         if (rec.walk_valid_0)
            rat[rec.walk_rd_id_0] <= rec.walk_rd_prf_0;
         if (rec.walk_valid_1)
            rat[rec.walk_rd_id_1] <= rec.walk_rd_prf_1;
      end else if (rename_en) begin
         if (rename_0.rd_valid)
            rat[rename_0.rd_id] <= rename_0.fl_prf_id;
         if (rename_1.rd_valid)
            rat[rename_1.rd_id] <= rename_1.fl_prf_id;
      end
   end

   //////////////////////////////
   // RRAT
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `ARF_NUM; i++)
            rrat[i] <= `PRF_WIDTH'(i);
      end else begin
         if (rec.retire_valid_0)
            rrat[rec.retire_arf_id_0] <= rec.retire_prf_id_0;
         if (rec.retire_valid_1)
            rrat[rec.retire_arf_id_1] <= rec.retire_prf_id_1; // Younger one wins
      end
   end

endmodule

`default_nettype wire

//--- source/free_list.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_config.svh"

module free_list (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  alloc_0,
   input  logic                  alloc_1,
   output logic [`PRF_WIDTH-1:0] alloc_prf_0,
   output logic [`PRF_WIDTH-1:0] alloc_prf_1,
   output logic [`PRF_WIDTH:0]   free_count,
   recovery_if.sink              rec
);

   logic [`PRF_WIDTH-1:0] pool [`PRF_NUM];
   logic [`PRF_WIDTH-1:0] head;
   logic [`PRF_WIDTH-1:0] tail;
   logic [`PRF_WIDTH-1:0] tail_1;
   logic [1:0]            n_alloc;
   logic [1:0]            n_release;
   logic [`PRF_WIDTH:0]   rewind;

   assign n_alloc   = {1'b0, alloc_0} + {1'b0, alloc_1};
   assign n_release = {1'b0, rec.release_valid_0} + {1'b0, rec.release_valid_1};

   // Squashed registers are still in the pool, behind the head
   assign rewind = (rec.rob_state == rename_pkg::rob_rollback) ?
                   (`PRF_WIDTH+1)'(rec.squash_count) : '0;

   // Slot 1 takes the next entry only when slot 0 allocates too
   assign alloc_prf_0 = pool[head];
   assign alloc_prf_1 = alloc_0 ? pool[head + 1'b1] : pool[head];

   assign tail_1 = rec.release_valid_0 ? tail + 1'b1 : tail;

   //////////////////////////////
   // Pointers and count
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         head       <= '0;
         tail       <= `PRF_WIDTH'(`PRF_NUM - `ARF_NUM);
         free_count <= (`PRF_WIDTH+1)'(`PRF_NUM - `ARF_NUM);
      end else begin
         head       <= head + `PRF_WIDTH'(n_alloc) - rewind[`PRF_WIDTH-1:0];
         tail       <= tail + `PRF_WIDTH'(n_release);
         free_count <= free_count + (`PRF_WIDTH+1)'(n_release)
                       - (`PRF_WIDTH+1)'(n_alloc) + rewind;
      end
   end

   //////////////////////////////
   // Pool storage
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         // Registers above the identity map start free, in order
         for (int i = 0; i < `PRF_NUM - `ARF_NUM; i++)
            pool[i] <= `PRF_WIDTH'(`ARF_NUM + i);
      end else begin
         if (rec.release_valid_0)
            pool[tail] <= rec.release_prf_0;
         if (rec.release_valid_1)
            pool[tail_1] <= rec.release_prf_1; // Behind slot 0
      end
   end

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
   input  logic [31:0]            instr_0,
   input  logic [31:0]            instr_1,
   output rename_pkg::rename_type rename_0,
   output rename_pkg::rename_type rename_1
);

   // Field extraction for one slot at RISC-V positions
   function automatic rename_pkg::rename_type decode(input logic [31:0] instr);
      rename_pkg::rename_type r;
      rename_pkg::opcode_e    op;
      op = rename_pkg::opcode_e'(instr[6:0]);
      r  = '0; // Unused fields stay zero
      case (op)
         rename_pkg::op_alu: begin
            r.rs1_id = instr[19:15];
            r.rs2_id = instr[24:20];
            r.rd_id  = instr[11:7];
         end
         rename_pkg::op_alui, rename_pkg::op_load: begin
            r.rs1_id = instr[19:15];
            r.rd_id  = instr[11:7];
         end
         rename_pkg::op_store, rename_pkg::op_branch: begin
            r.rs1_id = instr[19:15]; // No destination
            r.rs2_id = instr[24:20];
         end
         rename_pkg::op_lui: r.rd_id = instr[11:7];
         default: r = '0; // No-op
      endcase
      // x0 never gets a new mapping
      r.rd_valid = (r.rd_id != '0);
      return r;
   endfunction

   assign rename_0 = decode(instr_0);
   assign rename_1 = decode(instr_1);

endmodule

`default_nettype wire

//--- source/recovery_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "rename_config.svh"

interface recovery_if;

   rename_pkg::rob_state_e rob_state;

   // Retire into RRAT
   logic                  retire_valid_0;
   logic                  retire_valid_1;
   logic [`ARF_WIDTH-1:0] retire_arf_id_0;
   logic [`ARF_WIDTH-1:0] retire_arf_id_1;
   logic [`PRF_WIDTH-1:0] retire_prf_id_0;
   logic [`PRF_WIDTH-1:0] retire_prf_id_1;

   // Old mappings going back to the free list
   logic                  release_valid_0;
   logic                  release_valid_1;
   logic [`PRF_WIDTH-1:0] release_prf_0;
   logic [`PRF_WIDTH-1:0] release_prf_1;

   // Walk replay into RAT
   logic                  walk_valid_0;
   logic                  walk_valid_1;
   logic [`ARF_WIDTH-1:0] walk_rd_id_0;
   logic [`ARF_WIDTH-1:0] walk_rd_id_1;
   logic [`PRF_WIDTH-1:0] walk_rd_prf_0;
   logic [`PRF_WIDTH-1:0] walk_rd_prf_1;

   logic [`ROB_WIDTH:0]   squash_count; // Allocations dropped by a mispredict

   modport source (
      output rob_state,
      output retire_valid_0, retire_valid_1, retire_arf_id_0, retire_arf_id_1,
      output retire_prf_id_0, retire_prf_id_1,
      output release_valid_0, release_valid_1, release_prf_0, release_prf_1,
      output walk_valid_0, walk_valid_1, walk_rd_id_0, walk_rd_id_1,
      output walk_rd_prf_0, walk_rd_prf_1,
      output squash_count
   );

   modport sink (
      input rob_state,
      input retire_valid_0, retire_valid_1, retire_arf_id_0, retire_arf_id_1,
      input retire_prf_id_0, retire_prf_id_1,
      input release_valid_0, release_valid_1, release_prf_0, release_prf_1,
      input walk_valid_0, walk_valid_1, walk_rd_id_0, walk_rd_id_1,
      input walk_rd_prf_0, walk_rd_prf_1,
      input squash_count
   );

endinterface

`default_nettype wire

//--- source/rename_pkg.sv
`default_nettype none
`include "rename_config.svh"

package rename_pkg;

   // Major opcodes in RISC-V encoding
   typedef enum logic [6:0] {
      op_alu    = 7'b0110011,
      op_alui   = 7'b0010011,
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_branch = 7'b1100011,
      op_lui    = 7'b0110111
   } opcode_e;

   typedef enum logic [1:0] {
      rob_idle     = 2'd0,
      rob_rollback = 2'd1, // RAT reload from RRAT
      rob_walk     = 2'd2  // Replay of surviving renames
   } rob_state_e;

   // One rename slot
   typedef struct packed {
      logic [`ARF_WIDTH-1:0] rs1_id;
      logic [`ARF_WIDTH-1:0] rs2_id;
      logic [`ARF_WIDTH-1:0] rd_id;
      logic                  rd_valid;
      logic [`PRF_WIDTH-1:0] fl_prf_id; // Taken from the free list
   } rename_type;

endpackage

`default_nettype wire

//--- source/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Architectural register file
`define ARF_NUM   32
`define ARF_WIDTH 5

// Physical register file
`define PRF_NUM   64
`define PRF_WIDTH 6

// Rename ROB with two entries per renamed pair
`define ROB_DEPTH 16
`define ROB_WIDTH 4

`endif
